// ==== include/para_map.svh ====
// register offsets, multi-byte register bases and reset values of the monitor
`ifndef PARA_MAP_SVH
`define PARA_MAP_SVH

//---------------------------------------------------------------------------
// register offsets, multi-byte registers are little-endian
//---------------------------------------------------------------------------

// device id strap, read only
`define REG_ID      16'h0000

// threshold, 2 bytes
`define REG_TH      16'h0020
// high confirm time in clocks, 4 bytes
`define REG_HDT     16'h0024
// low confirm time in clocks, 4 bytes
`define REG_LDT     16'h0028
// blanking length in averages, 2 bytes
`define REG_SWT     16'h002c
// hit pulse width in clocks, 2 bytes
`define REG_HWT     16'h002e

// event counters, read only
`define REG_HITS    16'h0030
`define REG_RINGS   16'h0032

// latest average, read only
`define REG_AVE     16'h0050

// debug scratch bytes
`define REG_DBG     16'h0080
`define REG_DBG_N   16'd8

//---------------------------------------------------------------------------
// reset values
//---------------------------------------------------------------------------
`define RST_TH      16'h8000
`define RST_HDT     32'd100000
`define RST_LDT     32'd20000000
`define RST_SWT     16'd4
`define RST_HWT     16'd16
`define RST_DBG(n)  (8'h80 + 8'(n))

`endif

// ==== verilog/para_pkg.sv ====
// bus, sample, duration and counter typedefs plus the detector state enum
package para_pkg;

	//-----------------------------------------------------------------------
	// byte bus
	//-----------------------------------------------------------------------

	// [21:16] device id, [15:0] register offset
	typedef logic [21:0] bus_addr_t;

	typedef logic [7:0] bus_data_t;

	// strapped per device
	typedef logic [5:0] dev_id_t;

	//-----------------------------------------------------------------------
	// datapath
	//-----------------------------------------------------------------------

	// unsigned sample, also average and threshold
	typedef logic [15:0] sample_t;

	// confirmation times in clocks
	typedef logic [31:0] dur_t;

	// pulse width and blanking length
	typedef logic [15:0] wait_t;

	// hit and ring counts, wrapping
	typedef logic [15:0] count_t;

	// level detector
	typedef enum logic [2:0] {
		DET_LOW,
		DET_RISE,
		DET_HIGH,
		DET_FALL,
		DET_BLANK
	} det_state_t;

endpackage

// ==== verilog/para_regs.sv ====
// byte bus register block with config registers, debug bytes and read mux
`timescale 1ns/1ns

`include "para_map.svh"

module para_regs import para_pkg::*; (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  dev_id_t   dev_id,
	// byte bus
	input  logic      fx_wr,
	input  bus_addr_t fx_waddr,
	input  bus_data_t fx_data,
	input  logic      fx_rd,
	input  bus_addr_t fx_raddr,
	output bus_data_t fx_q,
	// status in
	input  sample_t   ave,
	input  count_t    hit_cnt,
	input  count_t    ring_cnt,
	// configuration out
	output sample_t   cfg_th,
	output dur_t      cfg_hdt,
	output dur_t      cfg_ldt,
	output wait_t     cfg_swt,
	output wait_t     cfg_hwt
);

	logic        wsel;
	logic        rsel;
	logic        now_wr;
	logic        now_rd;
	logic [15:0] woff;
	logic [15:0] roff;
	logic        wdbg;
	logic        rdbg;
	bus_data_t   dbg [8];

	//-----------------------------------------------------------------------
	// device select
	//-----------------------------------------------------------------------
	assign wsel = (fx_waddr[21:16] == dev_id);
	assign rsel = (fx_raddr[21:16] == dev_id);

	assign now_wr = fx_wr & wsel;
	assign now_rd = fx_rd & rsel;

	assign woff = fx_waddr[15:0];
	assign roff = fx_raddr[15:0];

	// debug window hits
	assign wdbg = (woff >= `REG_DBG) && (woff < `REG_DBG + `REG_DBG_N);
	assign rdbg = (roff >= `REG_DBG) && (roff < `REG_DBG + `REG_DBG_N);

	//-----------------------------------------------------------------------
	// byte writes
	//-----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cfg_th  <= `RST_TH;
			cfg_hdt <= `RST_HDT;
			cfg_ldt <= `RST_LDT;
			cfg_swt <= `RST_SWT;
			cfg_hwt <= `RST_HWT;
			for (int i = 0; i < 8; i++) begin
				dbg[i] <= `RST_DBG(i);
			end
		end else if (now_wr) begin
			if (wdbg) begin
				dbg[woff[2:0]] <= fx_data;
			end
			case (woff)
				`REG_TH          : cfg_th[7:0]    <= fx_data;
				`REG_TH + 16'd1  : cfg_th[15:8]   <= fx_data;
				`REG_HDT         : cfg_hdt[7:0]   <= fx_data;
				`REG_HDT + 16'd1 : cfg_hdt[15:8]  <= fx_data;
				`REG_HDT + 16'd2 : cfg_hdt[23:16] <= fx_data;
				`REG_HDT + 16'd3 : cfg_hdt[31:24] <= fx_data;
				`REG_LDT         : cfg_ldt[7:0]   <= fx_data;
				`REG_LDT + 16'd1 : cfg_ldt[15:8]  <= fx_data;
				`REG_LDT + 16'd2 : cfg_ldt[23:16] <= fx_data;
				`REG_LDT + 16'd3 : cfg_ldt[31:24] <= fx_data;
				`REG_SWT         : cfg_swt[7:0]   <= fx_data;
				`REG_SWT + 16'd1 : cfg_swt[15:8]  <= fx_data;
				`REG_HWT         : cfg_hwt[7:0]   <= fx_data;
				`REG_HWT + 16'd1 : cfg_hwt[15:8]  <= fx_data;
				// id, counters and average are read only
				default : ;
			endcase
		end
	end

	//-----------------------------------------------------------------------
	// registered read mux
	//-----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			fx_q <= '0;
		end else if (!now_rd) begin
			// idle bus reads as zero
			fx_q <= '0;
		end else if (rdbg) begin
			fx_q <= dbg[roff[2:0]];
		end else begin
			case (roff)
				`REG_ID            : fx_q <= {2'b00, dev_id};
				`REG_TH            : fx_q <= cfg_th[7:0];
				`REG_TH + 16'd1    : fx_q <= cfg_th[15:8];
				`REG_HDT           : fx_q <= cfg_hdt[7:0];
				`REG_HDT + 16'd1   : fx_q <= cfg_hdt[15:8];
				`REG_HDT + 16'd2   : fx_q <= cfg_hdt[23:16];
				`REG_HDT + 16'd3   : fx_q <= cfg_hdt[31:24];
				`REG_LDT           : fx_q <= cfg_ldt[7:0];
				`REG_LDT + 16'd1   : fx_q <= cfg_ldt[15:8];
				`REG_LDT + 16'd2   : fx_q <= cfg_ldt[23:16];
				`REG_LDT + 16'd3   : fx_q <= cfg_ldt[31:24];
				`REG_SWT           : fx_q <= cfg_swt[7:0];
				`REG_SWT + 16'd1   : fx_q <= cfg_swt[15:8];
				`REG_HWT           : fx_q <= cfg_hwt[7:0];
				`REG_HWT + 16'd1   : fx_q <= cfg_hwt[15:8];
				`REG_HITS          : fx_q <= hit_cnt[7:0];
				`REG_HITS + 16'd1  : fx_q <= hit_cnt[15:8];
				`REG_RINGS         : fx_q <= ring_cnt[7:0];
				`REG_RINGS + 16'd1 : fx_q <= ring_cnt[15:8];
				`REG_AVE           : fx_q <= ave[7:0];
				`REG_AVE + 16'd1   : fx_q <= ave[15:8];
				default            : fx_q <= '0;
			endcase
		end
	end

endmodule

// ==== verilog/para_avg.sv ====
// block averager over windows of 2**AVG_LOG2 samples
`timescale 1ns/1ns

module para_avg import para_pkg::*; #(
	parameter int AVG_LOG2 = 2
) (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  sample_t sample,
	input  logic    sample_valid,
	output sample_t ave,
	output logic    ave_valid
);

	// accumulator wide enough for a full window without overflow
	localparam int ACC_W = $bits(sample_t) + AVG_LOG2;

	logic [ACC_W-1:0]    acc;
	logic [ACC_W-1:0]    acc_nxt;
	logic [AVG_LOG2-1:0] win_cnt;
	logic                win_full;

	assign acc_nxt  = acc + ACC_W'(sample);
	assign win_full = &win_cnt;

	//-----------------------------------------------------------------------
	// accumulate and count
	//-----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			acc     <= '0;
			win_cnt <= '0;
		end else if (sample_valid) begin
			// window counter wraps back to zero on the last sample
			win_cnt <= win_cnt + 1'b1;
			if (win_full) begin
				acc <= '0;
			end else begin
				acc <= acc_nxt;
			end
		end
	end

	//-----------------------------------------------------------------------
	// output average
	//-----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ave       <= '0;
			ave_valid <= 1'b0;
		end else begin
			ave_valid <= 1'b0;
			if (sample_valid && win_full) begin
				// divide by window size, floor
				ave       <= acc_nxt[ACC_W-1:AVG_LOG2];
				ave_valid <= 1'b1;
			end
		end
	end

endmodule

// ==== verilog/para_det.sv ====
// level detector with rise/fall confirm, hit pulse, blanking and event counters
`timescale 1ns/1ns

module para_det import para_pkg::*; (
	input  logic    clk_sys,
	input  logic    rst_n,
	input  sample_t ave,
	input  logic    ave_valid,
	input  sample_t cfg_th,
	input  dur_t    cfg_hdt,
	input  dur_t    cfg_ldt,
	input  wait_t   cfg_swt,
	input  wait_t   cfg_hwt,
	output logic    hit,
	output count_t  hit_cnt,
	output count_t  ring_cnt
);

	det_state_t state;
	det_state_t state_nxt;
	dur_t       conf_cnt;
	wait_t      blank_cnt;
	wait_t      pulse_cnt;
	logic       above;
	logic       rise_done;
	logic       fall_done;

	assign above     = (ave >= cfg_th);
	assign rise_done = (state == DET_RISE) && above && (conf_cnt >= cfg_hdt);
	assign fall_done = (state == DET_FALL) && !above && (conf_cnt >= cfg_ldt);

	//-----------------------------------------------------------------------
	// next state
	//-----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			DET_LOW   : if (above) state_nxt = DET_RISE;
			DET_RISE  : begin
				if (!above) begin
					state_nxt = DET_LOW;
				end else if (rise_done) begin
					state_nxt = DET_HIGH;
				end
			end
			DET_HIGH  : if (!above) state_nxt = DET_FALL;
			DET_FALL  : begin
				if (above) begin
					state_nxt = DET_HIGH;
				end else if (fall_done) begin
					state_nxt = DET_BLANK;
				end
			end
			DET_BLANK : begin
				// zero length leaves after one clock
				if (blank_cnt == '0 || (ave_valid && blank_cnt == 16'd1)) begin
					state_nxt = DET_LOW;
				end
			end
			default   : state_nxt = DET_LOW;
		endcase
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state     <= DET_LOW;
			conf_cnt  <= '0;
			blank_cnt <= '0;
		end else begin
			state <= state_nxt;
			// consecutive clocks on the new side of the threshold
			if (state_nxt == DET_RISE || state_nxt == DET_FALL) begin
				conf_cnt <= (state_nxt == state) ? conf_cnt + 1'b1 : 32'd1;
			end else begin
				conf_cnt <= '0;
			end
			// blanking counts averages, not clocks
			if (fall_done) begin
				blank_cnt <= cfg_swt;
			end else if (state == DET_BLANK && ave_valid && blank_cnt != '0) begin
				blank_cnt <= blank_cnt - 1'b1;
			end
		end
	end

	//-----------------------------------------------------------------------
	// hit pulse and counters
	//-----------------------------------------------------------------------
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hit       <= 1'b0;
			pulse_cnt <= '0;
			hit_cnt   <= '0;
			ring_cnt  <= '0;
		end else begin
			if (rise_done) begin
				hit       <= (cfg_hwt != '0);
				pulse_cnt <= cfg_hwt;
				hit_cnt   <= hit_cnt + 1'b1;
			end else if (pulse_cnt != '0) begin
				// high for exactly cfg_hwt clocks
				hit       <= (pulse_cnt > 16'd1);
				pulse_cnt <= pulse_cnt - 1'b1;
			end
			if (fall_done) begin
				ring_cnt <= ring_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== verilog/para_mon_top.sv ====
// parameter monitor top with register block, averager and level detector
`timescale 1ns/1ns

module para_mon_top import para_pkg::*; #(
	parameter int AVG_LOG2 = 2
) (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  dev_id_t   dev_id,
	// byte bus
	input  logic      fx_wr,
	input  bus_addr_t fx_waddr,
	input  bus_data_t fx_data,
	input  logic      fx_rd,
	input  bus_addr_t fx_raddr,
	output bus_data_t fx_q,
	// sample stream
	input  sample_t   sample,
	input  logic      sample_valid,
	output logic      hit
);

	sample_t ave;
	logic    ave_valid;
	sample_t cfg_th;
	dur_t    cfg_hdt;
	dur_t    cfg_ldt;
	wait_t   cfg_swt;
	wait_t   cfg_hwt;
	count_t  hit_cnt;
	count_t  ring_cnt;

	para_regs para_regs_inst (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.dev_id   (dev_id),
		.fx_wr    (fx_wr),
		.fx_waddr (fx_waddr),
		.fx_data  (fx_data),
		.fx_rd    (fx_rd),
		.fx_raddr (fx_raddr),
		.fx_q     (fx_q),
		.ave      (ave),
		.hit_cnt  (hit_cnt),
		.ring_cnt (ring_cnt),
		.cfg_th   (cfg_th),
		.cfg_hdt  (cfg_hdt),
		.cfg_ldt  (cfg_ldt),
		.cfg_swt  (cfg_swt),
		.cfg_hwt  (cfg_hwt)
	);

	para_avg #(
		.AVG_LOG2 (AVG_LOG2)
	) para_avg_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.ave          (ave),
		.ave_valid    (ave_valid)
	);

	para_det para_det_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.ave       (ave),
		.ave_valid (ave_valid),
		.cfg_th    (cfg_th),
		.cfg_hdt   (cfg_hdt),
		.cfg_ldt   (cfg_ldt),
		.cfg_swt   (cfg_swt),
		.cfg_hwt   (cfg_hwt),
		.hit       (hit),
		.hit_cnt   (hit_cnt),
		.ring_cnt  (ring_cnt)
	);

endmodule

// ==== dv/para_mon_properties.sv ====
// concurrent checks on hit pulse width, hit counter steps and idle read data
`timescale 1ns/1ns

module para_mon_properties import para_pkg::*; (
	input logic       clk_sys,
	input logic       rst_n,
	input logic       hit,
	input count_t     hit_cnt,
	input wait_t      cfg_hwt,
	input det_state_t state,
	input logic       fx_rd,
	input bus_addr_t  fx_raddr,
	input dev_id_t    dev_id,
	input bus_data_t  fx_q
);

	// clocks of the current hit pulse so far
	int unsigned hit_run;

	// failed assertions so far
	int unsigned fails = 0;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			hit_run <= 0;
		end else begin
			hit_run <= hit ? hit_run + 1 : 0;
		end
	end

	//-----------------------------------------------------------------------
	// hit pulse
	//-----------------------------------------------------------------------
	hit_not_long: assert property (@(posedge clk_sys) disable iff (!rst_n)
		hit |-> (hit_run < cfg_hwt))
		else begin
			fails++;
			$error("hit pulse runs past %0d clocks", cfg_hwt);
		end

	hit_width: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$fell(hit) |-> (hit_run == cfg_hwt))
		else begin
			fails++;
			$error("hit pulse lasted %0d clocks, not %0d", hit_run, cfg_hwt);
		end

	//-----------------------------------------------------------------------
	// hit counter only steps on entry to DET_HIGH
	//-----------------------------------------------------------------------
	hit_cnt_step: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$stable(hit_cnt) |-> (hit_cnt == $past(hit_cnt) + 16'd1) &&
			(state == DET_HIGH) && ($past(state) == DET_RISE))
		else begin
			fails++;
			$error("hit counter changed outside a rise into DET_HIGH");
		end

	hit_cnt_on_rise: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(state == DET_HIGH && $past(state) == DET_RISE) |->
			(hit_cnt == $past(hit_cnt) + 16'd1))
		else begin
			fails++;
			$error("rise into DET_HIGH without a hit count");
		end

	//-----------------------------------------------------------------------
	// read data is zero unless a selected read came the cycle before
	//-----------------------------------------------------------------------
	idle_read_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$past(fx_rd && fx_raddr[21:16] == dev_id) |-> (fx_q == '0))
		else begin
			fails++;
			$error("read data 0x%0h without a selected read", fx_q);
		end

endmodule

// detector side with the bus ports tied off
bind para_det para_mon_properties det_props (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.hit      (hit),
	.hit_cnt  (hit_cnt),
	.cfg_hwt  (cfg_hwt),
	.state    (state),
	.fx_rd    (1'b0),
	.fx_raddr (22'd0),
	.dev_id   (6'd0),
	.fx_q     (8'd0)
);

// bus side with the detector ports tied off
bind para_regs para_mon_properties bus_props (
	.clk_sys  (clk_sys),
	.rst_n    (rst_n),
	.hit      (1'b0),
	.hit_cnt  (16'd0),
	.cfg_hwt  (16'd0),
	.state    (para_pkg::DET_LOW),
	.fx_rd    (fx_rd),
	.fx_raddr (fx_raddr),
	.dev_id   (dev_id),
	.fx_q     (fx_q)
);

// ==== dv/para_mon_tb.sv ====
// testbench with clock, reset, golden-file command player, checks and timeout
`timescale 1ns/1ns

module para_mon_tb import para_pkg::*; ();

	localparam string   GOLDEN = "dv/para_mon_golden.txt";
	localparam dev_id_t DEV_ID = 6'h15;

	logic      clk_sys;
	logic      rst_n;
	logic      fx_wr;
	bus_addr_t fx_waddr;
	bus_data_t fx_data;
	logic      fx_rd;
	bus_addr_t fx_raddr;
	bus_data_t fx_q;
	sample_t   sample;
	logic      sample_valid;
	logic      hit;

	string       cmd_q[$];
	string       test_name = "none";
	int unsigned cycles = 0;
	int unsigned cycle_limit = 0;
	int unsigned hit_cycles = 0;
	int unsigned errors = 0;
	int unsigned test_errors = 0;
	int unsigned tests_run = 0;
	int unsigned tests_failed = 0;

	para_mon_top #(
		.AVG_LOG2 (2)
	) para_mon_top_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.dev_id       (DEV_ID),
		.fx_wr        (fx_wr),
		.fx_waddr     (fx_waddr),
		.fx_data      (fx_data),
		.fx_rd        (fx_rd),
		.fx_raddr     (fx_raddr),
		.fx_q         (fx_q),
		.sample       (sample),
		.sample_valid (sample_valid),
		.hit          (hit)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// run length and hit pulse clocks
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (hit) begin
			hit_cycles <= hit_cycles + 1;
		end
	end

	initial begin : watchdog
		wait (cycle_limit != 0);
		wait (cycles >= cycle_limit);
		$display("timeout: run did not finish within %0d clock cycles", cycle_limit);
		$display("Result: FAILED");
		$finish;
	end

	//-----------------------------------------------------------------------
	// helpers
	//-----------------------------------------------------------------------
	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("[ERROR] %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	task automatic bus_write(input dev_id_t dev, input logic [15:0] off, input bus_data_t data);
		@(posedge clk_sys);
		fx_wr    <= 1'b1;
		fx_waddr <= {dev, off};
		fx_data  <= data;
		@(posedge clk_sys);
		fx_wr <= 1'b0;
	endtask

	task automatic bus_read(input dev_id_t dev, input logic [15:0] off, input bus_data_t exp);
		@(posedge clk_sys);
		fx_rd    <= 1'b1;
		fx_raddr <= {dev, off};
		@(posedge clk_sys);
		fx_rd <= 1'b0;
		// registered data has settled by the falling edge
		@(negedge clk_sys);
		check_value($sformatf("offset 0x%04h", off), fx_q, exp);
	endtask

	task automatic stream(input sample_t value, input int unsigned n);
		repeat (n) begin
			@(posedge clk_sys);
			sample       <= value;
			sample_valid <= 1'b1;
		end
		@(posedge clk_sys);
		sample_valid <= 1'b0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("test %s: pass", test_name);
		end else begin
			tests_failed++;
			$display("test %s: %0d mismatches", test_name, test_errors);
		end
	endtask

	// queue command lines and size the timeout
	task automatic load_golden(output bit ok);
		int          fd;
		string       line;
		string       rest;
		int unsigned a;
		int unsigned b;
		int unsigned total;
		fd    = $fopen(GOLDEN, "r");
		ok    = (fd != 0);
		total = 0;
		while (ok && !$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				cmd_q.push_back(line);
				rest = line.substr(1, line.len() - 1);
				case (line.getc(0))
					"S": begin
						void'($sscanf(rest, "%h %d", a, b));
						total += b;
					end
					"I": begin
						void'($sscanf(rest, "%d", a));
						total += a;
					end
					"W", "R": total += 4;
					default: ;
				endcase
			end
		end
		if (ok) begin
			$fclose(fd);
		end
		cycle_limit = 2 * total;
	endtask

	//-----------------------------------------------------------------------
	// main sequence
	//-----------------------------------------------------------------------
	initial begin : run
		string       line;
		string       rest;
		int unsigned a;
		int unsigned b;
		int unsigned c;
		int unsigned prop_fails;
		bit          loaded;
		rst_n        = 1'b0;
		fx_wr        = 1'b0;
		fx_waddr     = '0;
		fx_data      = '0;
		fx_rd        = 1'b0;
		fx_raddr     = '0;
		sample       = '0;
		sample_valid = 1'b0;
		load_golden(loaded);
		if (!loaded) begin
			$display("golden file %s could not be opened", GOLDEN);
		end else begin
			repeat (4) @(posedge clk_sys);
			rst_n <= 1'b1;
			foreach (cmd_q[i]) begin
				line = cmd_q[i];
				rest = line.substr(1, line.len() - 1);
				case (line.getc(0))
					"T": begin
						void'($sscanf(rest, "%s", test_name));
						test_errors = 0;
						hit_cycles  = 0;
					end
					"W": begin
						void'($sscanf(rest, "%h %h %h", a, b, c));
						bus_write(dev_id_t'(a), 16'(b), bus_data_t'(c));
					end
					"R": begin
						void'($sscanf(rest, "%h %h %h", a, b, c));
						bus_read(dev_id_t'(a), 16'(b), bus_data_t'(c));
					end
					"S": begin
						void'($sscanf(rest, "%h %d", a, b));
						stream(sample_t'(a), b);
					end
					"I": begin
						void'($sscanf(rest, "%d", a));
						repeat (a) @(posedge clk_sys);
					end
					"P": begin
						void'($sscanf(rest, "%d", a));
						check_value("hit high cycles", hit_cycles, a);
					end
					"E": end_test();
					default: begin
						errors++;
						$display("unknown golden command: %s", line);
					end
				endcase
			end
		end
		prop_fails = para_mon_top_inst.para_det_inst.det_props.fails +
			para_mon_top_inst.para_regs_inst.bus_props.fails;
		$display("tests: %0d passed, %0d failed, %0d mismatches, %0d assertion failures",
			tests_run - tests_failed, tests_failed, errors, prop_fails);
		if (loaded && errors == 0 && prop_fails == 0 && tests_failed == 0 && tests_run > 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== para_mon.f ====
+incdir+include
verilog/para_pkg.sv
verilog/para_regs.sv
verilog/para_avg.sv
verilog/para_det.sv
verilog/para_mon_top.sv
dv/para_mon_properties.sv
dv/para_mon_tb.sv

// ==== Bender.yml ====
package:
  name: para_mon

sources:
  - include_dirs:
      - include
    files:
      - verilog/para_pkg.sv
      - verilog/para_regs.sv
      - verilog/para_avg.sv
      - verilog/para_det.sv
      - verilog/para_mon_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/para_mon_properties.sv
      - dv/para_mon_tb.sv

// ==== dv/para_mon_golden.txt ====
# T name | W dev off data | R dev off expected | S value cycles | I cycles | P hit_cycles | E
# dev, off, data, expected and value in hex; cycles and hit_cycles in decimal
T reset_values
R 15 0000 15
R 15 0021 80
R 15 0024 a0
R 15 002b 01
R 15 002c 04
R 15 002e 10
R 15 0030 00
R 15 0051 00
R 15 0080 80
R 15 0087 87
E
T register_access
W 15 0021 70
W 15 0024 08
W 15 0025 00
W 15 0026 00
W 15 0028 08
W 15 0029 00
W 15 002a 00
W 15 002b 00
W 15 002c 02
W 15 002e 03
W 15 0083 5a
R 15 0021 70
R 15 0024 08
R 15 002b 00
R 15 002e 03
R 15 0083 5a
W 16 0083 ff
W 16 0020 11
R 15 0083 5a
R 15 0020 00
R 16 0083 00
W 15 0040 aa
R 15 0040 00
W 15 0000 3f
R 15 0000 15
W 15 0031 77
R 15 0031 00
E
T average
S 1234 8
R 15 0050 34
R 15 0051 12
S 1000 2
S 2001 2
R 15 0050 00
R 15 0051 18
E
T hit_and_ring
S 9000 24
S 1000 32
R 15 0030 01
R 15 0032 01
P 3
E
T short_excursions
S 9000 4
S 1000 4
R 15 0030 01
R 15 0032 01
S 9000 24
S 1000 4
S 9000 8
R 15 0030 02
R 15 0032 01
S 1000 32
R 15 0032 02
E
T repeated_events
S 9000 24
S 1000 32
S 9000 24
S 1000 32
S 9000 24
S 1000 32
R 15 0030 05
R 15 0032 05
P 9
E
